// ==== source/pat_isa_pkg.sv ====
package pat_isa_pkg;

	// ======================================================================
	// opcode and condition encodings
	// ======================================================================

	typedef enum logic [1:0]
	{
		COND_Z  = 2'd0,	// z flag set
		COND_NZ = 2'd1,	// z flag clear
		COND_N  = 2'd2,	// n flag set
		COND_AL = 2'd3	// always
	} pat_cond_e;

	// i8 opcodes, 15 opens the i3 space
	typedef enum logic [3:0]
	{
		OP8_OR = 4'd0, OP8_AND = 4'd1, OP8_ADDM = 4'd2, OP8_SUBM = 4'd3,
		OP8_ADD = 4'd4, OP8_SUB = 4'd5, OP8_LDI = 4'd6, OP8_LDM = 4'd7,
		OP8_BF = 4'd8, OP8_STM = 4'd11, OP8_ORM = 4'd13, OP8_ANDM = 4'd14,
		OP8_PREFIX = 4'd15
	} pat_op8_e;

	// i3 opcodes sit in imm8[7:4], 15 opens the i0 space
	typedef enum logic [3:0]
	{
		OP3_SHL = 4'd0, OP3_SHLO = 4'd1, OP3_SHR = 4'd2, OP3_ASR = 4'd3,
		OP3_IN = 4'd5, OP3_OUT = 4'd8, OP3_SETB = 4'd9, OP3_PREFIX = 4'd15
	} pat_op3_e;

	// i0 opcodes sit in imm8[3:0]
	typedef enum logic [3:0]
	{
		OP0_NOT = 4'd0, OP0_MOV = 4'd1, OP0_TEST = 4'd2, OP0_NOP = 4'd15
	} pat_op0_e;

	typedef enum logic [3:0]
	{
		ALU_OR, ALU_AND, ALU_NOT, ALU_ADD, ALU_SUB,
		ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR, ALU_PASS_B
	} pat_alu_op_e;

	// ======================================================================
	// instruction word and decoded control
	// ======================================================================

	typedef struct packed
	{
		logic [4:0] fieldp;	// field pointer
		pat_cond_e  cond;
		logic       field_op;	// 1 = operate on field buffer
		logic [3:0] op8;
		logic [7:0] imm8;	// also carries i3 / i0 opcodes
	} pat_instr_t;

	typedef struct packed
	{
		pat_alu_op_e alu_op;
		pat_cond_e   cond;
		logic        field_op;
		logic        dest_acc;
		logic        dest_field;
		logic        dest_dmem;	// stm
		logic        is_branch;	// bf
		logic        is_test;
		logic        is_out;
		logic        is_setb;
		logic        is_mov;
		logic        src_in;	// value comes from input port
		logic [7:0]  operand_b;	// memory data or immediate, muxed in stage 1
		logic [7:0]  imm;	// raw imm8 for branch, stm and setb
	} pat_ctrl_t;

	// i0 nop, always
	localparam pat_instr_t PAT_NOP = '{
		fieldp:   5'd0,
		cond:     COND_AL,
		field_op: 1'b0,
		op8:      4'hf,
		imm8:     8'hff
	};

endpackage

// ==== source/pat_datapath_pkg.sv ====
package pat_datapath_pkg;

	// ======================================================================
	// datapath word types
	// ======================================================================

	typedef logic [7:0] pat_data_t;		// accumulator / field / memory word
	typedef logic [9:0] pat_pc_t;		// instruction address
	typedef logic [2:0] pat_dmem_adr_t;	// 8-word data memory

	// write port towards the external field buffer
	typedef struct packed
	{
		pat_data_t data;
		logic      we_low;	// low bank strobe
		logic      we_high;	// high bank strobe
	} pat_field_wr_t;

endpackage

// ==== source/pat_alu.sv ====
`timescale 1ns/100ps

module pat_alu
(
	input  pat_datapath_pkg::pat_data_t i_a,
	input  pat_datapath_pkg::pat_data_t i_b,
	input  pat_isa_pkg::pat_alu_op_e    i_op,
	output pat_datapath_pkg::pat_data_t o_y
);

	logic [2:0]                  sh;	// shift distance
	pat_datapath_pkg::pat_data_t ones;	// fill mask for shlo

	assign sh = i_b[2:0];
	assign ones = ~(8'hff << sh);

	always_comb
	begin
		case (i_op)
			pat_isa_pkg::ALU_OR:   o_y = i_a | i_b;
			pat_isa_pkg::ALU_AND:  o_y = i_a & i_b;
			pat_isa_pkg::ALU_NOT:  o_y = ~i_a;
			pat_isa_pkg::ALU_ADD:  o_y = i_a + i_b;
			pat_isa_pkg::ALU_SUB:  o_y = i_a - i_b;	// wraps, no carry out
			pat_isa_pkg::ALU_SHL:  o_y = i_a << sh;
			pat_isa_pkg::ALU_SHLO: o_y = (i_a << sh) | ones;	// shift in ones
			pat_isa_pkg::ALU_SHR:  o_y = i_a >> sh;
			pat_isa_pkg::ALU_ASR:  o_y = $unsigned($signed(i_a) >>> sh);	// keep sign
			default:               o_y = i_b;	// pass b
		endcase
	end

endmodule

// ==== source/pat_decode.sv ====
`timescale 1ns/100ps

module pat_decode
(
	input  logic                          clk,
	input  logic                          reset,
	input  pat_isa_pkg::pat_instr_t       i_instruction,
	input  pat_datapath_pkg::pat_data_t   i_dmem_rdata,
	output pat_datapath_pkg::pat_dmem_adr_t o_dmem_radr,
	output logic [4:0]                    o_fieldp,
	output pat_isa_pkg::pat_ctrl_t        o_ctrl
);

	pat_isa_pkg::pat_instr_t  instr_q;	// stage-1 instruction register
	pat_isa_pkg::pat_ctrl_t   ctrl_d;
	pat_isa_pkg::pat_op8_e    op8;
	pat_isa_pkg::pat_op3_e    op3;
	pat_isa_pkg::pat_op0_e    op0;
	logic                     is_i8, is_i3;
	logic                     reg_write;	// op writes acc or field
	logic                     src_dmem;	// operand b from memory
	logic [7:0]               imm_all;

	assign op8 = pat_isa_pkg::pat_op8_e'(instr_q.op8);
	assign op3 = pat_isa_pkg::pat_op3_e'(instr_q.imm8[7:4]);
	assign op0 = pat_isa_pkg::pat_op0_e'(instr_q.imm8[3:0]);

	assign is_i8 = (op8 != pat_isa_pkg::OP8_PREFIX);
	assign is_i3 = !is_i8 && (op3 != pat_isa_pkg::OP3_PREFIX);	// else i0

	// i3 immediate is only 3 bits wide
	assign imm_all = is_i8 ? instr_q.imm8 : {5'd0, instr_q.imm8[2:0]};
	assign src_dmem = is_i8 && (op8 inside {pat_isa_pkg::OP8_LDM, pat_isa_pkg::OP8_ADDM,
		pat_isa_pkg::OP8_SUBM, pat_isa_pkg::OP8_ORM, pat_isa_pkg::OP8_ANDM});
	assign o_dmem_radr = instr_q.imm8[2:0];	// memory is read in stage 1

	always_comb
	begin
		ctrl_d = '0;
		reg_write = 1'b0;
		ctrl_d.alu_op = pat_isa_pkg::ALU_PASS_B;	// ldi / ldm / in / mov
		if (is_i8)
		begin
			case (op8)
				pat_isa_pkg::OP8_OR, pat_isa_pkg::OP8_ORM:
				begin
					ctrl_d.alu_op = pat_isa_pkg::ALU_OR;
					reg_write = 1'b1;
				end
				pat_isa_pkg::OP8_AND, pat_isa_pkg::OP8_ANDM:
				begin
					ctrl_d.alu_op = pat_isa_pkg::ALU_AND;
					reg_write = 1'b1;
				end
				pat_isa_pkg::OP8_ADD, pat_isa_pkg::OP8_ADDM:
				begin
					ctrl_d.alu_op = pat_isa_pkg::ALU_ADD;
					reg_write = 1'b1;
				end
				pat_isa_pkg::OP8_SUB, pat_isa_pkg::OP8_SUBM:
				begin
					ctrl_d.alu_op = pat_isa_pkg::ALU_SUB;
					reg_write = 1'b1;
				end
				pat_isa_pkg::OP8_LDI, pat_isa_pkg::OP8_LDM: reg_write = 1'b1;
				pat_isa_pkg::OP8_BF:  ctrl_d.is_branch = 1'b1;
				pat_isa_pkg::OP8_STM: ctrl_d.dest_dmem = 1'b1;
				default: ;	// unused codes behave as nop
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				pat_isa_pkg::OP3_SHL:  ctrl_d.alu_op = pat_isa_pkg::ALU_SHL;
				pat_isa_pkg::OP3_SHLO: ctrl_d.alu_op = pat_isa_pkg::ALU_SHLO;
				pat_isa_pkg::OP3_SHR:  ctrl_d.alu_op = pat_isa_pkg::ALU_SHR;
				pat_isa_pkg::OP3_ASR:  ctrl_d.alu_op = pat_isa_pkg::ALU_ASR;
				pat_isa_pkg::OP3_IN:   ctrl_d.src_in = 1'b1;
				pat_isa_pkg::OP3_OUT:  ctrl_d.is_out = 1'b1;
				pat_isa_pkg::OP3_SETB: ctrl_d.is_setb = 1'b1;
				default: ;
			endcase
			reg_write = (op3 inside {pat_isa_pkg::OP3_SHL, pat_isa_pkg::OP3_SHLO,
				pat_isa_pkg::OP3_SHR, pat_isa_pkg::OP3_ASR, pat_isa_pkg::OP3_IN});
		end
		else
		begin
			case (op0)
				pat_isa_pkg::OP0_NOT:
				begin
					ctrl_d.alu_op = pat_isa_pkg::ALU_NOT;
					reg_write = 1'b1;
				end
				pat_isa_pkg::OP0_MOV:
				begin
					ctrl_d.is_mov = 1'b1;	// direction set by field_op
					reg_write = 1'b1;
				end
				pat_isa_pkg::OP0_TEST: ctrl_d.is_test = 1'b1;
				default: ;	// nop and unlisted codes
			endcase
		end
		ctrl_d.cond = instr_q.cond;
		ctrl_d.field_op = instr_q.field_op;
		ctrl_d.dest_acc = reg_write && !instr_q.field_op;
		ctrl_d.dest_field = reg_write && instr_q.field_op;
		ctrl_d.operand_b = src_dmem ? i_dmem_rdata : imm_all;
		ctrl_d.imm = instr_q.imm8;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q <= pat_isa_pkg::PAT_NOP;
			o_ctrl <= '0;	// no destination, nothing commits
			o_fieldp <= '0;
		end
		else
		begin
			instr_q <= i_instruction;
			o_ctrl <= ctrl_d;
			o_fieldp <= instr_q.fieldp;
		end
	end

	// a writing op reaches stage 2 with exactly one destination
	a_one_dest: assert property (@(posedge clk) disable iff (reset)
		(reg_write || ctrl_d.dest_dmem) |=>
		$onehot({o_ctrl.dest_acc, o_ctrl.dest_field, o_ctrl.dest_dmem}));

endmodule

// ==== source/pat_acc_unit.sv ====
`timescale 1ns/100ps

module pat_acc_unit
(
	input  logic                        clk,
	input  logic                        reset,
	input  pat_isa_pkg::pat_ctrl_t      i_ctrl,
	input  logic                        i_commit_en,
	input  pat_datapath_pkg::pat_data_t i_inputs,
	input  pat_datapath_pkg::pat_data_t i_field_value,
	output pat_datapath_pkg::pat_data_t o_acc
);

	pat_datapath_pkg::pat_data_t alu_y;
	pat_datapath_pkg::pat_data_t acc_next;

	pat_alu u_acc_alu
	(
		.i_a  (o_acc),
		.i_b  (i_ctrl.operand_b),
		.i_op (i_ctrl.alu_op),
		.o_y  (alu_y)
	);

	// mov here always pulls from the field buffer
	assign acc_next = i_ctrl.is_mov ? i_field_value :
		i_ctrl.src_in ? i_inputs : alu_y;

	always_ff @(posedge clk)
	begin
		if (reset)
			o_acc <= '0;
		else if (i_commit_en && i_ctrl.dest_acc)
			o_acc <= acc_next;
	end

endmodule

// ==== source/pat_field_unit.sv ====
`timescale 1ns/100ps

module pat_field_unit
(
	input  logic                            clk,
	input  logic                            reset,
	input  pat_isa_pkg::pat_ctrl_t          i_ctrl,
	input  logic                            i_commit_en,
	input  pat_datapath_pkg::pat_data_t     i_field_low,
	input  pat_datapath_pkg::pat_data_t     i_field_high,
	input  pat_datapath_pkg::pat_data_t     i_inputs,
	input  pat_datapath_pkg::pat_data_t     i_acc,
	output pat_datapath_pkg::pat_data_t     o_field_value,
	output logic [2:0]                      o_bufp,
	output pat_datapath_pkg::pat_field_wr_t o_field_wr
);

	logic                        bank_high;	// 0 = low bank, 1 = high bank
	logic                        we_low_q, we_high_q;
	pat_datapath_pkg::pat_data_t wr_data_q;
	pat_datapath_pkg::pat_data_t alu_y;
	logic                        write_now;

	pat_alu u_field_alu
	(
		.i_a  (o_field_value),
		.i_b  (i_ctrl.operand_b),
		.i_op (i_ctrl.alu_op),
		.o_y  (alu_y)
	);

	assign write_now = i_commit_en && i_ctrl.dest_field;

	// sample selected bank once per cycle, seen by the op in stage 2
	always_ff @(posedge clk)
		o_field_value <= bank_high ? i_field_high : i_field_low;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bank_high <= 1'b0;
			o_bufp <= '0;
			we_low_q <= 1'b0;
			we_high_q <= 1'b0;
		end
		else
		begin
			if (i_commit_en && i_ctrl.is_setb)
			begin
				o_bufp <= i_ctrl.imm[2:0];
				bank_high <= i_ctrl.imm[3];	// bank bit above bufp
			end
			we_low_q <= write_now && !bank_high;	// single-cycle strobe
			we_high_q <= write_now && bank_high;
		end
	end

	// write data, mov here pushes the accumulator out
	always_ff @(posedge clk)
	begin
		if (write_now)
			wr_data_q <= i_ctrl.is_mov ? i_acc : i_ctrl.src_in ? i_inputs : alu_y;
	end

	assign o_field_wr = '{data: wr_data_q, we_low: we_low_q, we_high: we_high_q};

	a_one_bank: assert property (@(posedge clk) disable iff (reset)
		!(o_field_wr.we_low && o_field_wr.we_high));

endmodule

// ==== source/pat_commit.sv ====
`timescale 1ns/100ps

module pat_commit
#(
	parameter int BRANCH_SHADOW = 4
)
(
	input  logic                            clk,
	input  logic                            reset,
	input  pat_isa_pkg::pat_ctrl_t          i_ctrl,
	input  pat_datapath_pkg::pat_data_t     i_acc,
	input  pat_datapath_pkg::pat_data_t     i_field_value,
	output logic                            o_commit_en,
	output logic                            o_dmem_we,
	output pat_datapath_pkg::pat_dmem_adr_t o_dmem_wadr,
	output pat_datapath_pkg::pat_data_t     o_dmem_wdata,
	output pat_datapath_pkg::pat_pc_t       o_pc,
	output logic                            o_jump,
	output pat_datapath_pkg::pat_data_t     o_outputs
);

	localparam int SHADOW_W = $clog2(BRANCH_SHADOW + 1);

	logic                        z_q, n_q;	// flags from last test
	logic [SHADOW_W-1:0]         shadow_q;	// ops still to squash after bf
	logic                        cond_ok;
	logic                        take_branch;
	pat_datapath_pkg::pat_data_t src_val;	// acc or field, per field_op
	pat_datapath_pkg::pat_pc_t   offset;

	always_comb
	begin
		case (i_ctrl.cond)
			pat_isa_pkg::COND_Z:  cond_ok = z_q;
			pat_isa_pkg::COND_NZ: cond_ok = !z_q;
			pat_isa_pkg::COND_N:  cond_ok = n_q;
			default:              cond_ok = 1'b1;
		endcase
	end

	assign o_commit_en = cond_ok && (shadow_q == '0);
	assign take_branch = o_commit_en && i_ctrl.is_branch;
	assign src_val = i_ctrl.field_op ? i_field_value : i_acc;
	assign offset = {{2{i_ctrl.imm[7]}}, i_ctrl.imm};	// signed bf offset

	// stm goes straight to memory, written on this edge
	assign o_dmem_we = o_commit_en && i_ctrl.dest_dmem;
	assign o_dmem_wadr = i_ctrl.imm[2:0];
	assign o_dmem_wdata = src_val;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z_q <= 1'b0;
			n_q <= 1'b0;
			shadow_q <= '0;
			o_pc <= '0;
			o_jump <= 1'b0;
			o_outputs <= '0;
		end
		else
		begin
			o_pc <= take_branch ? o_pc + offset : o_pc + 10'd1;
			o_jump <= take_branch;	// one-cycle pulse
			if (take_branch)
				shadow_q <= SHADOW_W'(BRANCH_SHADOW);
			else if (shadow_q != '0)
				shadow_q <= shadow_q - 1'b1;
			if (o_commit_en && i_ctrl.is_test)
			begin
				z_q <= (src_val == '0);
				n_q <= src_val[7];
			end
			if (o_commit_en && i_ctrl.is_out)
				o_outputs <= i_acc;
		end
	end

	// shadow keeps a second bf from committing right behind the first
	a_jump_pulse: assert property (@(posedge clk) disable iff (reset)
		o_jump |=> !o_jump);

endmodule

// ==== source/pat_data_mem.sv ====
`timescale 1ns/100ps

module pat_data_mem
#(
	parameter int DEPTH = 8
)
(
	input  logic                            clk,
	input  pat_datapath_pkg::pat_dmem_adr_t i_radr,
	output pat_datapath_pkg::pat_data_t     o_rdata,
	input  logic                            i_we,
	input  pat_datapath_pkg::pat_dmem_adr_t i_wadr,
	input  pat_datapath_pkg::pat_data_t     i_wdata
);

	pat_datapath_pkg::pat_data_t mem [DEPTH];	// undefined until stored

	assign o_rdata = mem[i_radr];	// async read, used in stage 1

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_wadr] <= i_wdata;
	end

endmodule

// ==== source/pat_core.sv ====
`timescale 1ns/100ps

module pat_core
#(
	parameter int DMEM_DEPTH    = 8,
	parameter int BRANCH_SHADOW = 4
)
(
	input  logic                            clk,
	input  logic                            reset,
	input  pat_isa_pkg::pat_instr_t         i_instruction,
	input  pat_datapath_pkg::pat_data_t     i_field_low,
	input  pat_datapath_pkg::pat_data_t     i_field_high,
	input  pat_datapath_pkg::pat_data_t     i_inputs,
	output pat_datapath_pkg::pat_pc_t       o_pc,
	output logic                            o_jump,
	output logic [4:0]                      o_fieldp,
	output logic [2:0]                      o_bufp,
	output pat_datapath_pkg::pat_field_wr_t o_field_wr,
	output pat_datapath_pkg::pat_data_t     o_outputs
);

	// ======================================================================
	// stage 1 to stage 2 wiring
	// ======================================================================

	pat_isa_pkg::pat_ctrl_t          ctrl;
	logic                            commit_en;
	pat_datapath_pkg::pat_data_t     acc;
	pat_datapath_pkg::pat_data_t     field_value;
	pat_datapath_pkg::pat_dmem_adr_t dmem_radr, dmem_wadr;
	pat_datapath_pkg::pat_data_t     dmem_rdata, dmem_wdata;
	logic                            dmem_we;

	pat_decode u_decode
	(
		.clk (clk), .reset (reset),
		.i_instruction (i_instruction),
		.i_dmem_rdata  (dmem_rdata),
		.o_dmem_radr   (dmem_radr),
		.o_fieldp      (o_fieldp),
		.o_ctrl        (ctrl)
	);

	pat_acc_unit u_acc_unit
	(
		.clk (clk), .reset (reset),
		.i_ctrl (ctrl), .i_commit_en (commit_en),
		.i_inputs (i_inputs), .i_field_value (field_value),
		.o_acc (acc)
	);

	pat_field_unit u_field_unit
	(
		.clk (clk), .reset (reset),
		.i_ctrl (ctrl), .i_commit_en (commit_en),
		.i_field_low (i_field_low), .i_field_high (i_field_high),
		.i_inputs (i_inputs), .i_acc (acc),
		.o_field_value (field_value), .o_bufp (o_bufp), .o_field_wr (o_field_wr)
	);

	pat_commit #(.BRANCH_SHADOW (BRANCH_SHADOW)) u_commit
	(
		.clk (clk), .reset (reset),
		.i_ctrl (ctrl), .i_acc (acc), .i_field_value (field_value),
		.o_commit_en (commit_en),
		.o_dmem_we (dmem_we), .o_dmem_wadr (dmem_wadr), .o_dmem_wdata (dmem_wdata),
		.o_pc (o_pc), .o_jump (o_jump), .o_outputs (o_outputs)
	);

	pat_data_mem #(.DEPTH (DMEM_DEPTH)) u_data_mem
	(
		.clk (clk),
		.i_radr (dmem_radr), .o_rdata (dmem_rdata),
		.i_we (dmem_we), .i_wadr (dmem_wadr), .i_wdata (dmem_wdata)
	);

endmodule

// ==== testbench/pat_tb.sv ====
`timescale 1ns/100ps

module pat_tb;

	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 10;
	localparam int BRANCH_SHADOW = 4;
	localparam int MAX_LEN       = 512;	// room for program plus drain

	// expected architectural state after each commit edge
	typedef struct packed
	{
		pat_datapath_pkg::pat_data_t     acc;
		logic                            z;
		logic                            n;
		logic                            bank_high;
		logic [2:0]                      bufp;
		pat_datapath_pkg::pat_pc_t       pc;
		logic                            jump;
		pat_datapath_pkg::pat_data_t     outputs;
		pat_datapath_pkg::pat_field_wr_t fwr;
		logic [2:0]                      shadow;	// ops left to squash
		logic [7:0][7:0]                 mem;
	} model_t;

	logic                            clk;
	logic                            reset;
	pat_isa_pkg::pat_instr_t         i_instruction;
	pat_datapath_pkg::pat_data_t     i_field_low;
	pat_datapath_pkg::pat_data_t     i_field_high;
	pat_datapath_pkg::pat_data_t     i_inputs;
	pat_datapath_pkg::pat_pc_t       o_pc;
	logic                            o_jump;
	logic [4:0]                      o_fieldp;
	logic [2:0]                      o_bufp;
	pat_datapath_pkg::pat_field_wr_t o_field_wr;
	pat_datapath_pkg::pat_data_t     o_outputs;

	integer                      seed = 5094;
	pat_isa_pkg::pat_instr_t     prog [$];	// instruction stream
	pat_datapath_pkg::pat_data_t in_val [MAX_LEN];	// per-cycle input port
	pat_datapath_pkg::pat_data_t fl_low [MAX_LEN];	// per-cycle field banks
	pat_datapath_pkg::pat_data_t fl_high [MAX_LEN];
	int                          prog_len = 0;
	int                          errors = 0;
	int                          checks = 0;
	model_t                      model;

	pat_core #(.DMEM_DEPTH (8), .BRANCH_SHADOW (BRANCH_SHADOW)) u_pat_core
	(
		.clk (clk), .reset (reset),
		.i_instruction (i_instruction),
		.i_field_low (i_field_low), .i_field_high (i_field_high),
		.i_inputs (i_inputs),
		.o_pc (o_pc), .o_jump (o_jump), .o_fieldp (o_fieldp),
		.o_bufp (o_bufp), .o_field_wr (o_field_wr), .o_outputs (o_outputs)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ======================================================================
	// instruction encoding helpers
	// ======================================================================

	function automatic pat_datapath_pkg::pat_data_t rand_byte();
		return pat_datapath_pkg::pat_data_t'($random(seed));
	endfunction

	function automatic pat_isa_pkg::pat_instr_t i8_word(pat_isa_pkg::pat_op8_e op,
		logic [7:0] imm, logic fop = 1'b0, pat_isa_pkg::pat_cond_e cond = pat_isa_pkg::COND_AL);
		pat_isa_pkg::pat_instr_t w;
		w = '{fieldp: 5'd0, cond: cond, field_op: fop, op8: op, imm8: imm};
		return w;
	endfunction

	// i3 word, arg lands in imm8[3:0]
	function automatic pat_isa_pkg::pat_instr_t i3_word(pat_isa_pkg::pat_op3_e op,
		logic [3:0] arg, logic fop = 1'b0, pat_isa_pkg::pat_cond_e cond = pat_isa_pkg::COND_AL);
		pat_isa_pkg::pat_instr_t w;
		w = '{fieldp: 5'd0, cond: cond, field_op: fop, op8: 4'hf, imm8: {op, arg}};
		return w;
	endfunction

	function automatic pat_isa_pkg::pat_instr_t i0_word(pat_isa_pkg::pat_op0_e op,
		logic fop = 1'b0, pat_isa_pkg::pat_cond_e cond = pat_isa_pkg::COND_AL);
		pat_isa_pkg::pat_instr_t w;
		w = '{fieldp: 5'd0, cond: cond, field_op: fop, op8: 4'hf, imm8: {4'hf, op}};
		return w;
	endfunction

	task automatic emit(pat_isa_pkg::pat_instr_t ins);
		ins.fieldp = 5'($random(seed));	// pointer only travels to o_fieldp
		prog.push_back(ins);
	endtask

	// ======================================================================
	// program sections
	// ======================================================================

	task automatic acc_tests();
		pat_isa_pkg::pat_op3_e shifts [4];
		shifts = '{pat_isa_pkg::OP3_SHL, pat_isa_pkg::OP3_SHLO,
			pat_isa_pkg::OP3_SHR, pat_isa_pkg::OP3_ASR};
		repeat (3)
		begin
			emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_OR, rand_byte()));
			emit(i8_word(pat_isa_pkg::OP8_AND, rand_byte()));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_ADD, rand_byte()));
			emit(i8_word(pat_isa_pkg::OP8_SUB, rand_byte()));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i0_word(pat_isa_pkg::OP0_NOT));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i3_word(pat_isa_pkg::OP3_IN, 4'd0));	// value from i_inputs
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			foreach (shifts[s])
			begin
				emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
				emit(i3_word(shifts[s], 4'(rand_byte() & 8'h07)));
				emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			end
		end
	endtask

	task automatic mem_tests();
		pat_datapath_pkg::pat_data_t adr;
		for (int a = 0; a < 8; a++)	// fill every word before any load
		begin
			emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
			emit(i8_word(pat_isa_pkg::OP8_STM, 8'(a)));
		end
		emit(pat_isa_pkg::PAT_NOP);	// spacer, load reads in stage 1
		repeat (2)
		begin
			adr = rand_byte() & 8'h07;
			emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
			emit(i8_word(pat_isa_pkg::OP8_ADDM, adr));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_SUBM, adr));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_ORM, adr));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_ANDM, adr));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_LDM, adr));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		end
		emit(i8_word(pat_isa_pkg::OP8_STM, 8'd5, 1'b1));	// store the field value
		emit(pat_isa_pkg::PAT_NOP);
		emit(i8_word(pat_isa_pkg::OP8_LDM, 8'd5));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
	endtask

	task automatic field_tests();
		pat_datapath_pkg::pat_data_t r;
		for (int b = 0; b < 2; b++)
		begin
			r = rand_byte();
			emit(i3_word(pat_isa_pkg::OP3_SETB, {b[0], r[2:0]}));	// bank bit then bufp
			emit(pat_isa_pkg::PAT_NOP);	// bank settles before next field read
			emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte(), 1'b1));
			emit(i8_word(pat_isa_pkg::OP8_OR, rand_byte(), 1'b1));
			emit(i8_word(pat_isa_pkg::OP8_AND, rand_byte(), 1'b1));
			emit(i8_word(pat_isa_pkg::OP8_ADD, rand_byte(), 1'b1));
			emit(i8_word(pat_isa_pkg::OP8_SUB, rand_byte(), 1'b1));
			emit(i8_word(pat_isa_pkg::OP8_ORM, r & 8'h07, 1'b1));
			emit(i0_word(pat_isa_pkg::OP0_NOT, 1'b1));
			emit(i3_word(pat_isa_pkg::OP3_SHL, 4'(r & 8'h07), 1'b1));
			emit(i3_word(pat_isa_pkg::OP3_SHLO, 4'(rand_byte() & 8'h07), 1'b1));
			emit(i3_word(pat_isa_pkg::OP3_SHR, 4'(rand_byte() & 8'h07), 1'b1));
			emit(i3_word(pat_isa_pkg::OP3_ASR, 4'(rand_byte() & 8'h07), 1'b1));
			emit(i3_word(pat_isa_pkg::OP3_IN, 4'd0, 1'b1));
			emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
			emit(i0_word(pat_isa_pkg::OP0_MOV, 1'b1));	// acc into field
			emit(i0_word(pat_isa_pkg::OP0_MOV, 1'b0));	// field into acc
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i0_word(pat_isa_pkg::OP0_TEST, 1'b1));
		end
	endtask

	task automatic branch_tests();
		emit(i8_word(pat_isa_pkg::OP8_LDI, 8'h00));
		emit(i0_word(pat_isa_pkg::OP0_TEST));	// z set, n clear
		emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte(), 1'b0, pat_isa_pkg::COND_Z));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte(), 1'b0, pat_isa_pkg::COND_NZ));
		emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte(), 1'b0, pat_isa_pkg::COND_N));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		emit(i8_word(pat_isa_pkg::OP8_LDI, 8'h90));
		emit(i0_word(pat_isa_pkg::OP0_TEST));	// z clear, n set
		emit(i8_word(pat_isa_pkg::OP8_ADD, rand_byte(), 1'b0, pat_isa_pkg::COND_N));
		emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte(), 1'b0, pat_isa_pkg::COND_Z));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		emit(i8_word(pat_isa_pkg::OP8_SUB, rand_byte(), 1'b0, pat_isa_pkg::COND_NZ));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		emit(i0_word(pat_isa_pkg::OP0_TEST, 1'b1));	// flags from field value
		emit(i8_word(pat_isa_pkg::OP8_OR, rand_byte(), 1'b0, pat_isa_pkg::COND_NZ));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		// taken forward and backward branches, each with a full shadow
		for (int k = 0; k < 2; k++)
		begin
			emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
			emit(i8_word(pat_isa_pkg::OP8_BF, k == 0 ? 8'h25 : 8'hf0 | rand_byte()));
			repeat (BRANCH_SHADOW)
				emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
			emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
		end
		emit(i8_word(pat_isa_pkg::OP8_LDI, 8'h01));
		emit(i0_word(pat_isa_pkg::OP0_TEST));
		emit(i8_word(pat_isa_pkg::OP8_BF, rand_byte(), 1'b0, pat_isa_pkg::COND_Z));	// not taken
		emit(i8_word(pat_isa_pkg::OP8_LDI, rand_byte()));
		emit(i3_word(pat_isa_pkg::OP3_OUT, 4'd0));
	endtask

	// ======================================================================
	// reference model, one commit edge per call
	// ======================================================================

	function automatic model_t ref_step(model_t m, pat_isa_pkg::pat_instr_t ins,
		pat_datapath_pkg::pat_data_t in_v, pat_datapath_pkg::pat_data_t fval);
		model_t                      r;
		logic                        ok;
		logic                        wr;
		logic                        taken;
		logic [2:0]                  sh;
		logic [15:0]                 wide;
		pat_datapath_pkg::pat_data_t a;
		pat_datapath_pkg::pat_data_t mem_v;
		pat_datapath_pkg::pat_data_t res;
		r = m;
		r.jump = 1'b0;
		r.fwr.we_low = 1'b0;	// strobes last one cycle
		r.fwr.we_high = 1'b0;
		wr = 1'b0;
		taken = 1'b0;
		res = '0;
		wide = '0;
		case (ins.cond)
			pat_isa_pkg::COND_Z:  ok = m.z;
			pat_isa_pkg::COND_NZ: ok = !m.z;
			pat_isa_pkg::COND_N:  ok = m.n;
			default:              ok = 1'b1;
		endcase
		if (m.shadow != 3'd0)	// squashed behind a taken bf
		begin
			ok = 1'b0;
			r.shadow = m.shadow - 3'd1;
		end
		a = ins.field_op ? fval : m.acc;	// first operand
		mem_v = m.mem[ins.imm8[2:0]];
		sh = ins.imm8[2:0];
		if (ok && ins.op8 != 4'hf)
		begin
			wr = 1'b1;
			case (ins.op8)
				pat_isa_pkg::OP8_OR:   res = a | ins.imm8;
				pat_isa_pkg::OP8_AND:  res = a & ins.imm8;
				pat_isa_pkg::OP8_ADD:  res = a + ins.imm8;
				pat_isa_pkg::OP8_SUB:  res = a - ins.imm8;
				pat_isa_pkg::OP8_LDI:  res = ins.imm8;
				pat_isa_pkg::OP8_ORM:  res = a | mem_v;
				pat_isa_pkg::OP8_ANDM: res = a & mem_v;
				pat_isa_pkg::OP8_ADDM: res = a + mem_v;
				pat_isa_pkg::OP8_SUBM: res = a - mem_v;
				pat_isa_pkg::OP8_LDM:  res = mem_v;
				pat_isa_pkg::OP8_STM:
				begin
					wr = 1'b0;
					r.mem[ins.imm8[2:0]] = a;
				end
				pat_isa_pkg::OP8_BF:
				begin
					wr = 1'b0;
					taken = 1'b1;
				end
				default: wr = 1'b0;
			endcase
		end
		else if (ok && ins.imm8[7:4] != 4'hf)
		begin
			wr = 1'b1;
			case (ins.imm8[7:4])
				pat_isa_pkg::OP3_SHL: res = a << sh;
				pat_isa_pkg::OP3_SHLO:
				begin
					wide = {a, 8'hff} << sh;	// ones follow a in
					res = wide[15:8];
				end
				pat_isa_pkg::OP3_SHR: res = a >> sh;
				pat_isa_pkg::OP3_ASR:
				begin
					wide = {{8{a[7]}}, a} >> sh;
					res = wide[7:0];
				end
				pat_isa_pkg::OP3_IN: res = in_v;
				pat_isa_pkg::OP3_OUT:
				begin
					wr = 1'b0;
					r.outputs = m.acc;
				end
				pat_isa_pkg::OP3_SETB:
				begin
					wr = 1'b0;
					r.bufp = ins.imm8[2:0];
					r.bank_high = ins.imm8[3];
				end
				default: wr = 1'b0;
			endcase
		end
		else if (ok)
		begin
			case (ins.imm8[3:0])
				pat_isa_pkg::OP0_NOT:
				begin
					wr = 1'b1;
					res = ~a;
				end
				pat_isa_pkg::OP0_MOV:
				begin
					wr = 1'b1;
					res = ins.field_op ? m.acc : fval;	// opposite side is the source
				end
				pat_isa_pkg::OP0_TEST:
				begin
					r.z = (a == 8'h00);
					r.n = a[7];
				end
				default: ;
			endcase
		end
		if (wr && ins.field_op)
		begin
			r.fwr.data = res;
			r.fwr.we_low = !m.bank_high;
			r.fwr.we_high = m.bank_high;
		end
		else if (wr)
			r.acc = res;
		if (taken)
		begin
			r.jump = 1'b1;
			r.shadow = 3'(BRANCH_SHADOW);
			r.pc = pat_datapath_pkg::pat_pc_t'(int'(m.pc) + int'($signed(ins.imm8)));
		end
		else
			r.pc = m.pc + 10'd1;
		return r;
	endfunction

	// ======================================================================
	// compare tasks
	// ======================================================================

	task automatic check_data(string name, pat_datapath_pkg::pat_data_t got,
		pat_datapath_pkg::pat_data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_pc(pat_datapath_pkg::pat_pc_t got, pat_datapath_pkg::pat_pc_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error o_pc: got %h, expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_ptr(string name, logic [4:0] got, logic [4:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// data only matters while a strobe is up
	task automatic check_field_wr(pat_datapath_pkg::pat_field_wr_t got,
		pat_datapath_pkg::pat_field_wr_t exp);
		checks++;
		if (got.we_low !== exp.we_low || got.we_high !== exp.we_high)
		begin
			errors++;
			$display("error o_field_wr enables: got %h, expected %h at %0t",
				{got.we_low, got.we_high}, {exp.we_low, exp.we_high}, $time);
		end
		else if ((exp.we_low || exp.we_high) && got.data !== exp.data)
		begin
			errors++;
			$display("error o_field_wr.data: got %h, expected %h at %0t",
				got.data, exp.data, $time);
		end
	endtask

	// ======================================================================
	// stimulus, compare and watchdog processes
	// ======================================================================

	initial
	begin : stimulus
		reset = 1'b1;
		i_instruction = pat_isa_pkg::PAT_NOP;
		i_inputs = '0;
		i_field_low = '0;
		i_field_high = '0;
		for (int k = 0; k < MAX_LEN; k++)
		begin
			in_val[k] = rand_byte();
			fl_low[k] = rand_byte();
			fl_high[k] = rand_byte();
		end
		acc_tests();
		mem_tests();
		field_tests();
		branch_tests();
		prog_len = prog.size();
		repeat (RESET_CYCLES) @(posedge clk);
		for (int n = 0; n <= prog_len + 4; n++)
		begin
			@(negedge clk);
			if (n == 0)
				reset = 1'b0;
			i_instruction = (n < prog_len) ? prog[n] : pat_isa_pkg::PAT_NOP;
			i_inputs = in_val[n];
			i_field_low = fl_low[n];
			i_field_high = fl_high[n];
		end
	end

	// negedge n sees the commit of instruction n-3 (captured at posedge n-3)
	initial
	begin : compare
		pat_isa_pkg::pat_instr_t     ins;
		pat_datapath_pkg::pat_data_t fval;
		logic [4:0]                  fieldp_exp;
		int                          j;
		int                          k;
		model = '0;
		@(negedge reset);
		for (int n = 0; n <= prog_len + 4; n++)
		begin
			if (n > 0)
			begin
				@(negedge clk);
				j = n - 3;
				k = (n >= 2) ? n - 2 : 0;	// field sample taken at posedge j+1
				ins = (j >= 0 && j < prog_len) ? prog[j] : pat_isa_pkg::PAT_NOP;
				fval = model.bank_high ? fl_high[k] : fl_low[k];
				model = ref_step(model, ins, in_val[n - 1], fval);
			end
			fieldp_exp = (n >= 2 && n - 2 < prog_len) ? prog[n - 2].fieldp : 5'd0;
			check_pc(o_pc, model.pc);
			check_bit("o_jump", o_jump, model.jump);
			check_data("o_outputs", o_outputs, model.outputs);
			check_field_wr(o_field_wr, model.fwr);
			check_ptr("o_bufp", {2'b00, o_bufp}, {2'b00, model.bufp});
			check_ptr("o_fieldp", o_fieldp, fieldp_exp);
		end
		$display("%0d instructions, %0d checks, %0d errors", prog_len, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin : watchdog
		wait (prog_len != 0);
		#((prog_len + 20) * CLK_PERIOD * 2);
		$display("watchdog expired before the instruction stream finished");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
source/pat_isa_pkg.sv
source/pat_datapath_pkg.sv
source/pat_alu.sv
source/pat_decode.sv
source/pat_acc_unit.sv
source/pat_field_unit.sv
source/pat_commit.sv
source/pat_data_mem.sv
source/pat_core.sv
testbench/pat_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert -Wno-fatal -j 0
TOP       = pat_tb
FILELIST  = compile.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
